// ==== hdl/mduDecoder.sv ====
module mduDecoder (
	input mipsPkg::instrWord instr,
	output mduPkg::mduOp op,
	output mipsPkg::regIndex destReg
);

	logic [5:0] opcode;
	mipsPkg::functCode funct;

	assign opcode = instr[31:26];
	assign funct = mipsPkg::functCode'(instr[5:0]);

	//////////////////////////////////////////////////////////////////////
	// Funct to operation
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = mduPkg::NONE;
		if (opcode == mipsPkg::opcodeSpecial)
		begin
			case (funct)
				mipsPkg::FN_MULT:
					op = mduPkg::MULT;
				mipsPkg::FN_MULTU:
					op = mduPkg::MULTU;
				mipsPkg::FN_DIV:
					op = mduPkg::DIV;
				mipsPkg::FN_DIVU:
					op = mduPkg::DIVU;
				mipsPkg::FN_MTHI:
					op = mduPkg::MTHI;
				mipsPkg::FN_MTLO:
					op = mduPkg::MTLO;
				mipsPkg::FN_MFHI:
					op = mduPkg::MFHI;
				mipsPkg::FN_MFLO:
					op = mduPkg::MFLO;
				// Other R-type ops belong to the ALU
				default:
					op = mduPkg::NONE;
			endcase
		end
	end

	// Move-from ops name their destination GPR in rd
	assign destReg = (op == mduPkg::MFHI || op == mduPkg::MFLO) ? instr[15:11] : '0;

endmodule

// ==== hdl/mduExecute.sv ====
`include "mdu_defines.svh"

module mduExecute (
	input logic clk,
	input logic reset,
	input mipsPkg::instrWord instr,
	input logic instrValid,
	input logic [`MDU_WIDTH-1:0] rsValue,
	input logic [`MDU_WIDTH-1:0] rtValue,
	output logic stall,
	output logic resultValid,
	output logic [`MDU_WIDTH-1:0] result,
	output mipsPkg::regIndex resultReg
);

	typedef struct packed
	{
		logic [`MDU_WIDTH-1:0] data;
		mipsPkg::regIndex dest;
	} resultPayload;

	mduPkg::mduOp decodedOp;
	mipsPkg::regIndex decodedDest;
	logic accept;
	logic willBusy;
	mduPkg::issuePayload issueIn;
	mduPkg::issuePayload issueOut;
	logic issueValid;
	logic unitStart;
	logic readHiLo;
	logic [`MDU_WIDTH-1:0] hi;
	logic [`MDU_WIDTH-1:0] lo;
	resultPayload resultIn;
	resultPayload resultOut;

	//////////////////////////////////////////////////////////////////////
	// Decode and issue
	//////////////////////////////////////////////////////////////////////

	mduDecoder decoder (.instr(instr), .op(decodedOp), .destReg(decodedDest));

	mduHazard hazard (
		.op(decodedOp),
		.instrValid(instrValid),
		.willBusy(willBusy),
		.stall(stall),
		.accept(accept)
	);

	assign issueIn = '{op: decodedOp, dest: decodedDest, rs: rsValue, rt: rtValue};

	pipeRegister #(.payloadT(mduPkg::issuePayload)) issueReg (
		.clk(clk),
		.reset(reset),
		.load(accept),
		.dataIn(issueIn),
		.valid(issueValid),
		.dataOut(issueOut)
	);

	//////////////////////////////////////////////////////////////////////
	// Unit and HI/LO read
	//////////////////////////////////////////////////////////////////////

	assign unitStart = issueValid && (issueOut.op inside {mduPkg::MULT, mduPkg::MULTU,
		mduPkg::DIV, mduPkg::DIVU, mduPkg::MTHI, mduPkg::MTLO});

	multDivUnit unit (
		.clk(clk),
		.reset(reset),
		.start(unitStart),
		.op(issueOut.op),
		.srcA(issueOut.rs),
		.srcB(issueOut.rt),
		.hi(hi),
		.lo(lo),
		.busy(),
		.willBusy(willBusy)
	);

	// Move-from reads see any mthi/mtlo written on the previous edge
	assign readHiLo = issueValid && (issueOut.op == mduPkg::MFHI || issueOut.op == mduPkg::MFLO);
	assign resultIn.data = (issueOut.op == mduPkg::MFHI) ? hi : lo;
	assign resultIn.dest = issueOut.dest;

	pipeRegister #(.payloadT(resultPayload)) resultStage (
		.clk(clk),
		.reset(reset),
		.load(readHiLo),
		.dataIn(resultIn),
		.valid(resultValid),
		.dataOut(resultOut)
	);

	assign result = resultOut.data;
	assign resultReg = resultOut.dest;

endmodule

// ==== hdl/mduHazard.sv ====
module mduHazard (
	input mduPkg::mduOp op,
	input logic instrValid,
	input logic willBusy,
	output logic stall,
	output logic accept
);

	logic needsUnit;

	// Anything touching HI/LO must wait for the unit
	always_comb
	begin
		case (op)
			mduPkg::MULT, mduPkg::MULTU, mduPkg::DIV, mduPkg::DIVU,
			mduPkg::MTHI, mduPkg::MTLO, mduPkg::MFHI, mduPkg::MFLO:
				needsUnit = 1'b1;
			default:
				needsUnit = 1'b0;
		endcase
	end

	// willBusy low means the unit is free by the next cycle
	assign stall = instrValid && needsUnit && willBusy;

	// Issue slot takes a bubble when nothing is accepted
	assign accept = instrValid && !stall;

endmodule

// ==== hdl/mdu_defines.svh ====
`ifndef MDU_DEFINES_SVH
`define MDU_DEFINES_SVH

// Width of operands and of each of HI and LO
`define MDU_WIDTH 32

// Busy cycles following the start cycle
`define MULT_CYCLES 5
`define DIV_CYCLES 10

`endif

// ==== hdl/mdu_pkg.sv ====
`include "mdu_defines.svh"

package mduPkg;

	// Operations understood by the HI/LO unit and the result path
	typedef enum logic [3:0]
	{
		NONE,
		MULT,
		MULTU,
		DIV,
		DIVU,
		MTLO,
		MTHI,
		MFLO,
		MFHI
	} mduOp;

	// Contents of the issue slot
	typedef struct packed
	{
		mduOp op;
		mipsPkg::regIndex dest;
		logic [`MDU_WIDTH-1:0] rs;
		logic [`MDU_WIDTH-1:0] rt;
	} issuePayload;

endpackage

// ==== hdl/mips_pkg.sv ====
package mipsPkg;

	// One instruction word
	typedef logic [31:0] instrWord;

	// GPR number held in the rs, rt and rd fields
	typedef logic [4:0] regIndex;

	// Primary opcode shared by all R-type instructions
	localparam logic [5:0] opcodeSpecial = 6'h00;

	// Funct values handled by the multiply/divide stage
	typedef enum logic [5:0]
	{
		FN_MFHI  = 6'h10,
		FN_MTHI  = 6'h11,
		FN_MFLO  = 6'h12,
		FN_MTLO  = 6'h13,
		FN_MULT  = 6'h18,
		FN_MULTU = 6'h19,
		FN_DIV   = 6'h1a,
		FN_DIVU  = 6'h1b
	} functCode;

endpackage

// ==== hdl/multDivUnit.sv ====
`include "mdu_defines.svh"

module multDivUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input mduPkg::mduOp op,
	input logic [`MDU_WIDTH-1:0] srcA,
	input logic [`MDU_WIDTH-1:0] srcB,
	output logic [`MDU_WIDTH-1:0] hi,
	output logic [`MDU_WIDTH-1:0] lo,
	output logic busy,
	output logic willBusy
);

	localparam int width = `MDU_WIDTH;
	localparam int countBits = $clog2(`DIV_CYCLES + 1);

	logic [countBits-1:0] count;
	logic [countBits-1:0] latency;
	logic longOp;
	logic [width-1:0] aReg;
	logic [width-1:0] bReg;
	mduPkg::mduOp opReg;
	logic signed [2*width-1:0] prodSigned;
	logic [2*width-1:0] prodUnsigned;
	logic [width-1:0] hiNext;
	logic [width-1:0] loNext;

	// Latency of the op being started
	always_comb
	begin
		longOp = 1'b1;
		latency = '0;
		case (op)
			mduPkg::MULT, mduPkg::MULTU:
				latency = countBits'(`MULT_CYCLES);
			mduPkg::DIV, mduPkg::DIVU:
				latency = countBits'(`DIV_CYCLES);
			default:
				longOp = 1'b0;
		endcase
	end

	assign busy = (count != '0);
	// Lookahead covers a long op starting now or more than the final cycle left
	assign willBusy = (count > countBits'(1)) || (start && longOp);

	//////////////////////////////////////////////////////////////////////
	// Arithmetic on the latched operands
	//////////////////////////////////////////////////////////////////////

	assign prodSigned = (2*width)'($signed(aReg)) * (2*width)'($signed(bReg));
	assign prodUnsigned = (2*width)'(aReg) * (2*width)'(bReg);

	always_comb
	begin
		hiNext = hi;
		loNext = lo;
		case (opReg)
			mduPkg::MULT:
				{hiNext, loNext} = prodSigned;
			mduPkg::MULTU:
				{hiNext, loNext} = prodUnsigned;
			mduPkg::DIV:
			begin
				// Quotient truncates toward zero and the remainder takes the dividend's sign
				loNext = $signed(aReg) / $signed(bReg);
				hiNext = $signed(aReg) % $signed(bReg);
			end
			mduPkg::DIVU:
			begin
				loNext = aReg / bReg;
				hiNext = aReg % bReg;
			end
			default:
			begin
				hiNext = hi;
				loNext = lo;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// HI/LO and countdown
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hi <= '0;
			lo <= '0;
			count <= '0;
		end
		else
		begin
			// Final busy cycle commits the result
			if (count == countBits'(1))
			begin
				hi <= hiNext;
				lo <= loNext;
			end
			if (start)
			begin
				count <= latency;
				if (op == mduPkg::MTHI)
					hi <= srcA;
				if (op == mduPkg::MTLO)
					lo <= srcA;
			end
			else if (count != '0)
			begin
				count <= count - countBits'(1);
			end
		end
	end

	// Operand capture
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			aReg <= srcA;
			bReg <= srcB;
			opReg <= op;
		end
	end

endmodule

// ==== hdl/pipeRegister.sv ====
module pipeRegister #(
	parameter type payloadT = logic
)(
	input logic clk,
	input logic reset,
	input logic load,
	input payloadT dataIn,
	output logic valid,
	output payloadT dataOut
);

	// Slot empties to a bubble when not loaded
	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= 1'b0;
		else
			valid <= load;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			dataOut <= dataIn;
	end

endmodule

// ==== mduExecute.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/mdu_pkg.sv
hdl/mduDecoder.sv
hdl/multDivUnit.sv
hdl/mduHazard.sv
hdl/pipeRegister.sv
hdl/mduExecute.sv
tests/clockGen.sv
tests/mduExecute_sva.sv
tests/mduExecuteTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the mduExecute testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mduExecuteTb -Mdir obj_dir -f mduExecute.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/VmduExecuteTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== tests/clockGen.sv ====
module clockGen #(
	parameter int period = 40
)(
	output logic clk
);

	// First rising edge comes half a period in
	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

endmodule

// ==== tests/mduExecuteTb.sv ====
`include "mdu_defines.svh"

module mduExecuteTb;

	localparam int maxLines = 64;
	localparam int wordsPerLine = 4;
	localparam int driveDelay = 2;
	localparam int resetCycles = 3;

	logic clk;
	logic reset;
	mipsPkg::instrWord instr;
	logic instrValid;
	logic [`MDU_WIDTH-1:0] rsValue;
	logic [`MDU_WIDTH-1:0] rtValue;
	logic stall;
	logic resultValid;
	logic [`MDU_WIDTH-1:0] result;
	mipsPkg::regIndex resultReg;

	logic [31:0] stimulus [0:maxLines*wordsPerLine-1];
	logic [31:0] expectedData [$];
	logic [4:0] expectedReg [$];
	string expectedName [$];
	logic [31:0] lfsr;
	logic stallSeen;
	int lineCount;
	int timeoutLimit = 0;
	int cycleCount = 0;
	int mismatchCount = 0;
	int strayCount = 0;
	int otherCount = 0;

	clockGen #(.period(40)) clockSource (.clk(clk));

	mduExecute uut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.stall(stall),
		.resultValid(resultValid),
		.result(result),
		.resultReg(resultReg)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Marks words the file did not overwrite
	function automatic logic [31:0] fillWord(input int addr);
		return 32'hf0f0_0000 ^ 32'(addr);
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic logic isMoveFrom(input logic [31:0] word);
		return word[31:26] == 6'h00 &&
			(word[5:0] == mipsPkg::FN_MFHI || word[5:0] == mipsPkg::FN_MFLO);
	endfunction

	// Two LFSR bits give 0 to 3 idle cycles
	task automatic drawGap(output int gap);
		logic [1:0] bits;
		lfsr = lfsrNext(lfsr);
		bits[0] = lfsr[0];
		lfsr = lfsrNext(lfsr);
		bits[1] = lfsr[0];
		gap = int'(bits);
	endtask

	// Holds one instruction until the stage takes it
	task automatic issueLine(input int idx);
		logic [31:0] word;
		logic accepted;
		word = stimulus[idx*wordsPerLine];
		instr = word;
		rsValue = stimulus[idx*wordsPerLine+1];
		rtValue = stimulus[idx*wordsPerLine+2];
		instrValid = 1'b1;
		do
		begin
			@(negedge clk);
			accepted = !stall;
			if (stall)
				stallSeen = 1'b1;
			@(posedge clk);
		end while (!accepted);
		#driveDelay;
		instrValid = 1'b0;
		if (isMoveFrom(word))
		begin
			expectedData.push_back(stimulus[idx*wordsPerLine+3]);
			expectedReg.push_back(word[15:11]);
			expectedName.push_back($sformatf("line %0d %s", idx + 1,
				word[1] ? "mflo" : "mfhi"));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result checking, in issue order
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		logic [31:0] expData;
		logic [4:0] expReg;
		string name;
		if (!reset && resultValid)
		begin
			assert (expectedData.size() != 0)
			else
			begin
				$display("Result %08h returned with no mfhi or mflo pending", result);
				strayCount++;
			end
			if (expectedData.size() != 0)
			begin
				expData = expectedData.pop_front();
				expReg = expectedReg.pop_front();
				name = expectedName.pop_front();
				assert (result === expData)
				else
				begin
					$display("Mismatch %s result expected %08h actual %08h",
						name, expData, result);
					mismatchCount++;
				end
				assert (resultReg === expReg)
				else
				begin
					$display("Mismatch %s resultReg expected %0d actual %0d",
						name, expReg, resultReg);
					mismatchCount++;
				end
			end
		end
	end

	// Run limit
	always @(posedge clk)
	begin
		cycleCount++;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
		begin
			$display("Timeout after %0d cycles with %0d results outstanding",
				cycleCount, expectedData.size());
			$display("Errors: %0d mismatches, %0d stray results, %0d other",
				mismatchCount, strayCount, otherCount + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int idx;
		int gap;
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		rsValue = '0;
		rtValue = '0;
		stallSeen = 1'b0;
		lfsr = 32'h8c16_b45d;

		for (idx = 0; idx < maxLines * wordsPerLine; idx++)
			stimulus[idx] = fillWord(idx);
		$readmemh("tests/mdu_stimulus.txt", stimulus);
		lineCount = 0;
		while (lineCount < maxLines &&
			stimulus[lineCount*wordsPerLine] != fillWord(lineCount * wordsPerLine))
			lineCount++;
		// Worst line is a gap, a stalled wait and a full divide
		timeoutLimit = lineCount * (`DIV_CYCLES + 6) + resetCycles;

		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		@(negedge clk);
		assert (!stall && !resultValid)
		else
		begin
			$display("stall or resultValid high after reset");
			otherCount++;
		end
		assert (lineCount > 0)
		else
		begin
			$display("No instructions read from the stimulus file");
			otherCount++;
		end
		@(posedge clk);
		#driveDelay;

		for (idx = 0; idx < lineCount; idx++)
		begin
			drawGap(gap);
			if (gap > 0)
			begin
				repeat (gap) @(posedge clk);
				#driveDelay;
			end
			issueLine(idx);
		end

		while (expectedData.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		assert (stallSeen)
		else
		begin
			$display("stall never rose for an instruction following mult or div");
			otherCount++;
		end

		$display("Errors: %0d mismatches, %0d stray results, %0d other",
			mismatchCount, strayCount, otherCount);
		if (mismatchCount == 0 && strayCount == 0 && otherCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== tests/mduExecute_sva.sv ====
`include "mdu_defines.svh"

module mduExecuteSva #(
	parameter int countBits = $clog2(`DIV_CYCLES + 1)
)(
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic [countBits-1:0] count
);

	// Countdown cleared by reset
	busyAfterReset: assert property (@(posedge clk) reset |=> !busy)
		else $error("busy high in the cycle after reset");

	// A busy period always begins with a start
	busyNeedsStart: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> $past(start))
		else $error("busy rose without a start in the previous cycle");

	// Only the final busy cycle may overlap a new start
	startWhenFree: assert property (@(posedge clk) disable iff (reset)
		start |-> (count <= countBits'(1)))
		else $error("start while two or more busy cycles remain");

endmodule

bind multDivUnit mduExecuteSva unitChecks (
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.count(count)
);

// ==== tests/mdu_stimulus.txt ====
// Columns: instruction word, rs value, rt value, expected mfhi/mflo result
// rs and rt are unused on mf lines, the last column is unused on all others
00001010 00000000 00000000 00000000
00001812 00000000 00000000 00000000
01090018 fffffffb 00000007 00000000
00002010 00000000 00000000 ffffffff
00002812 00000000 00000000 ffffffdd
01090019 ffffffff ffffffff 00000000
00001010 00000000 00000000 fffffffe
00001812 00000000 00000000 00000001
0109001a ffffffe5 00000004 00000000
00002812 00000000 00000000 fffffffa
00002010 00000000 00000000 fffffffd
0109001b ffffffe5 00000004 00000000
00001812 00000000 00000000 3ffffff9
00001010 00000000 00000000 00000001
01000011 12345678 00000000 00000000
01000013 9abcdef0 00000000 00000000
00002010 00000000 00000000 12345678
00002812 00000000 00000000 9abcdef0
00430820 00000001 00000002 00000000
0109001a 00000064 fffffff9 00000000
00001812 00000000 00000000 fffffff2
00001010 00000000 00000000 00000002
